// ==== include/core_consts.svh ====
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// instruction queue
`define IQ_DEPTH 4

// 2RI14 opcodes, instr[31:24]
`define EXE_LL_W 8'h20
`define EXE_SC_W 8'h21

// 2RI12 opcodes, instr[31:22]
`define EXE_ADDI_W 10'h00A
`define EXE_LD_B   10'h0A0
`define EXE_LD_H   10'h0A1
`define EXE_LD_W   10'h0A2
`define EXE_ST_B   10'h0A4
`define EXE_ST_H   10'h0A5
`define EXE_ST_W   10'h0A6

// alu operations
`define EXE_NOP_OP   8'h00
`define EXE_ADD_OP   8'h01
`define EXE_LL_OP    8'h02
`define EXE_SC_OP    8'h03
`define EXE_LOAD_OP  8'h04
`define EXE_STORE_OP 8'h05

// alu result select
`define EXE_RES_NOP        3'b000
`define EXE_RES_ARITH      3'b001
`define EXE_RES_MOVE       3'b011
`define EXE_RES_LOAD_STORE 3'b111

`endif

// ==== verilog/core_types.sv ====
`default_nettype none

package core_types;

    // one fetched instruction as it sits in the queue
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
    } instr_buffer_info_t;

endpackage

`default_nettype wire

// ==== verilog/decode_types.sv ====
`default_nettype none

package decode_types;

    // general purpose register index
    typedef logic [4:0] gpr_addr_t;

    // memory access size, byte is the zero encoding
    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_width_t;

endpackage

`default_nettype wire

// ==== verilog/instr_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_consts.svh"

module instr_queue
    import core_types::*;
#(
    parameter int DEPTH = `IQ_DEPTH
) (
    input  wire logic               clk,
    input  wire logic               rst_i,
    input  wire logic               push_i,
    input  wire logic [31:0]        pc_i,
    input  wire logic [31:0]        instr_i,
    input  wire logic               pop_i,
    output instr_buffer_info_t      entry_o,
    output logic                    not_empty_o,
    output logic                    full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

    instr_buffer_info_t mem [DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full_o      = (count == CNT_W'(DEPTH));
    assign not_empty_o = (count != '0);

    // a push into a full queue is dropped, even alongside a pop
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && not_empty_o;

    // head shown without a register so the stage can take it this cycle
    assign entry_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= '{pc: pc_i, instr: instr_i};
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/decoder_2RI14.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_consts.svh"

// 2RI14 layout {opcode[8], imm[14], rj[5], rd[5]}
module decoder_2RI14
    import core_types::*;
    import decode_types::*;
(
    input  wire instr_buffer_info_t instr_info_i,

    // high when the opcode belongs to this format
    output logic                    match_o,

    // read ports, valid bits {rk slot, rj slot}, addresses {second, first}
    output logic [1:0]              reg_read_valid_o,
    output logic [9:0]              reg_read_addr_o,

    output logic                    use_imm_o,
    output logic [31:0]             imm_o,

    output logic                    reg_write_valid_o,
    output gpr_addr_t               reg_write_addr_o,

    output logic [7:0]              aluop_o,
    output logic [2:0]              alusel_o,

    output logic                    mem_load_o,
    output logic                    mem_store_o
);

    logic [31:0] instr;
    gpr_addr_t   rd;
    gpr_addr_t   rj;
    logic [13:0] imm_14;
    logic [31:0] imm_word;

    assign instr  = instr_info_i.instr;
    assign rd     = instr[4:0];
    assign rj     = instr[9:5];
    assign imm_14 = instr[23:10];

    // sign extended, then scaled to a word offset
    assign imm_word = {{18{imm_14[13]}}, imm_14} << 2;

    always_comb begin
        match_o           = 1'b0;
        reg_read_valid_o  = 2'b00;
        reg_read_addr_o   = '0;
        use_imm_o         = 1'b0;
        imm_o             = '0;
        reg_write_valid_o = 1'b0;
        reg_write_addr_o  = '0;
        aluop_o           = `EXE_NOP_OP;
        alusel_o          = `EXE_RES_NOP;
        mem_load_o        = 1'b0;
        mem_store_o       = 1'b0;
        case (instr[31:24])
            `EXE_LL_W: begin
                match_o           = 1'b1;
                aluop_o           = `EXE_LL_OP;
                alusel_o          = `EXE_RES_MOVE;
                reg_write_valid_o = 1'b1;
                reg_write_addr_o  = rd;
                reg_read_valid_o  = 2'b01;
                reg_read_addr_o   = {5'b0, rj};
                imm_o             = imm_word;
                mem_load_o        = 1'b1;
            end
            `EXE_SC_W: begin
                match_o           = 1'b1;
                aluop_o           = `EXE_SC_OP;
                alusel_o          = `EXE_RES_MOVE;
                // rd is both the store data and the success flag
                reg_write_valid_o = 1'b1;
                reg_write_addr_o  = rd;
                reg_read_valid_o  = 2'b11;
                reg_read_addr_o   = {rd, rj};
                imm_o             = imm_word;
                mem_store_o       = 1'b1;
            end
            default: begin
                match_o = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/decoder_2RI12.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_consts.svh"

// 2RI12 layout {opcode[10], imm[12], rj[5], rd[5]}
module decoder_2RI12
    import core_types::*;
    import decode_types::*;
(
    input  wire instr_buffer_info_t instr_info_i,

    // high when the opcode belongs to this format
    output logic                    match_o,

    // read ports, valid bits {rk slot, rj slot}, addresses {second, first}
    output logic [1:0]              reg_read_valid_o,
    output logic [9:0]              reg_read_addr_o,

    output logic                    use_imm_o,
    output logic [31:0]             imm_o,

    output logic                    reg_write_valid_o,
    output gpr_addr_t               reg_write_addr_o,

    output logic [7:0]              aluop_o,
    output logic [2:0]              alusel_o,

    output logic                    mem_load_o,
    output logic                    mem_store_o,
    output mem_width_t              mem_width_o
);

    logic [31:0] instr;
    logic [9:0]  opcode;
    gpr_addr_t   rd;
    gpr_addr_t   rj;
    logic [31:0] imm_sext;

    assign instr    = instr_info_i.instr;
    assign opcode   = instr[31:22];
    assign rd       = instr[4:0];
    assign rj       = instr[9:5];
    assign imm_sext = {{20{instr[21]}}, instr[21:10]};

    always_comb begin
        match_o           = 1'b0;
        reg_read_valid_o  = 2'b00;
        reg_read_addr_o   = '0;
        use_imm_o         = 1'b0;
        imm_o             = '0;
        reg_write_valid_o = 1'b0;
        reg_write_addr_o  = '0;
        aluop_o           = `EXE_NOP_OP;
        alusel_o          = `EXE_RES_NOP;
        mem_load_o        = 1'b0;
        mem_store_o       = 1'b0;
        mem_width_o       = MEM_BYTE;
        case (opcode)
            `EXE_ADDI_W: begin
                match_o           = 1'b1;
                aluop_o           = `EXE_ADD_OP;
                alusel_o          = `EXE_RES_ARITH;
                reg_write_valid_o = 1'b1;
                reg_write_addr_o  = rd;
                reg_read_valid_o  = 2'b01;
                reg_read_addr_o   = {5'b0, rj};
                use_imm_o         = 1'b1;
                imm_o             = imm_sext;
            end
            `EXE_LD_B, `EXE_LD_H, `EXE_LD_W: begin
                match_o           = 1'b1;
                aluop_o           = `EXE_LOAD_OP;
                alusel_o          = `EXE_RES_LOAD_STORE;
                reg_write_valid_o = 1'b1;
                reg_write_addr_o  = rd;
                reg_read_valid_o  = 2'b01;
                reg_read_addr_o   = {5'b0, rj};
                imm_o             = imm_sext;
                mem_load_o        = 1'b1;
                // low opcode bits give the access size
                mem_width_o       = mem_width_t'(opcode[1:0]);
            end
            `EXE_ST_B, `EXE_ST_H, `EXE_ST_W: begin
                match_o           = 1'b1;
                aluop_o           = `EXE_STORE_OP;
                alusel_o          = `EXE_RES_LOAD_STORE;
                // rd carries the store data
                reg_read_valid_o  = 2'b11;
                reg_read_addr_o   = {rd, rj};
                imm_o             = imm_sext;
                mem_store_o       = 1'b1;
                mem_width_o       = mem_width_t'(opcode[1:0]);
            end
            default: begin
                match_o = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/decode_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_consts.svh"

module decode_stage
    import core_types::*;
    import decode_types::*;
(
    input  wire logic               clk,
    input  wire logic               rst_i,
    input  wire instr_buffer_info_t entry_i,
    input  wire logic               not_empty_i,
    input  wire logic               stall_i,
    output logic                    pop_o,

    output logic                    dec_valid_o,
    output logic [31:0]             dec_pc_o,
    output logic                    illegal_o,
    output logic [7:0]              aluop_o,
    output logic [2:0]              alusel_o,
    output logic [1:0]              reg_read_valid_o,
    output logic [9:0]              reg_read_addr_o,
    output logic                    reg_write_valid_o,
    output gpr_addr_t               reg_write_addr_o,
    output logic                    use_imm_o,
    output logic [31:0]             imm_o,
    output logic                    mem_load_o,
    output logic                    mem_store_o,
    output mem_width_t              mem_width_o
);

    // per-format decoder results
    logic        m14;
    logic [1:0]  rv14;
    logic [9:0]  ra14;
    logic        ui14;
    logic [31:0] imm14;
    logic        wv14;
    gpr_addr_t   wa14;
    logic [7:0]  op14;
    logic [2:0]  sel14;
    logic        ld14;
    logic        st14;

    logic        m12;
    logic [1:0]  rv12;
    logic [9:0]  ra12;
    logic        ui12;
    logic [31:0] imm12;
    logic        wv12;
    gpr_addr_t   wa12;
    logic [7:0]  op12;
    logic [2:0]  sel12;
    logic        ld12;
    logic        st12;
    mem_width_t  wd12;

    decoder_2RI14 u_dec_2ri14 (
        .instr_info_i      (entry_i),
        .match_o           (m14),
        .reg_read_valid_o  (rv14),
        .reg_read_addr_o   (ra14),
        .use_imm_o         (ui14),
        .imm_o             (imm14),
        .reg_write_valid_o (wv14),
        .reg_write_addr_o  (wa14),
        .aluop_o           (op14),
        .alusel_o          (sel14),
        .mem_load_o        (ld14),
        .mem_store_o       (st14)
    );

    decoder_2RI12 u_dec_2ri12 (
        .instr_info_i      (entry_i),
        .match_o           (m12),
        .reg_read_valid_o  (rv12),
        .reg_read_addr_o   (ra12),
        .use_imm_o         (ui12),
        .imm_o             (imm12),
        .reg_write_valid_o (wv12),
        .reg_write_addr_o  (wa12),
        .aluop_o           (op12),
        .alusel_o          (sel12),
        .mem_load_o        (ld12),
        .mem_store_o       (st12),
        .mem_width_o       (wd12)
    );

    assign pop_o = not_empty_i && !stall_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            dec_valid_o       <= 1'b0;
            illegal_o         <= 1'b0;
            aluop_o           <= `EXE_NOP_OP;
            alusel_o          <= `EXE_RES_NOP;
            reg_read_valid_o  <= 2'b00;
            reg_write_valid_o <= 1'b0;
            use_imm_o         <= 1'b0;
            mem_load_o        <= 1'b0;
            mem_store_o       <= 1'b0;
        end else begin
            // valid is a single cycle pulse per pop
            dec_valid_o <= pop_o;
            if (pop_o) begin
                illegal_o         <= !m14 && !m12;
                aluop_o           <= m14 ? op14 : (m12 ? op12 : `EXE_NOP_OP);
                alusel_o          <= m14 ? sel14 : (m12 ? sel12 : `EXE_RES_NOP);
                reg_read_valid_o  <= m14 ? rv14 : (m12 ? rv12 : 2'b00);
                reg_write_valid_o <= m14 ? wv14 : (m12 && wv12);
                use_imm_o         <= m14 ? ui14 : (m12 && ui12);
                mem_load_o        <= m14 ? ld14 : (m12 && ld12);
                mem_store_o       <= m14 ? st14 : (m12 && st12);
            end
        end
    end

    // payload fields, only meaningful next to a valid pulse
    always_ff @(posedge clk) begin
        if (pop_o) begin
            dec_pc_o         <= entry_i.pc;
            reg_read_addr_o  <= m14 ? ra14 : (m12 ? ra12 : '0);
            reg_write_addr_o <= m14 ? wa14 : (m12 ? wa12 : '0);
            imm_o            <= m14 ? imm14 : (m12 ? imm12 : '0);
            // ll/sc are always word accesses
            mem_width_o      <= m14 ? MEM_WORD : (m12 ? wd12 : MEM_BYTE);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/decode_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_top
    import core_types::*;
    import decode_types::*;
(
    input  wire logic        clk,
    input  wire logic        rst_i,

    // fetch side
    input  wire logic        push_i,
    input  wire logic [31:0] pc_i,
    input  wire logic [31:0] instr_i,
    output logic             full_o,

    // downstream back-pressure
    input  wire logic        stall_i,

    output logic             dec_valid_o,
    output logic [31:0]      dec_pc_o,
    output logic             illegal_o,
    output logic [7:0]       aluop_o,
    output logic [2:0]       alusel_o,
    output logic [1:0]       reg_read_valid_o,
    output logic [9:0]       reg_read_addr_o,
    output logic             reg_write_valid_o,
    output gpr_addr_t        reg_write_addr_o,
    output logic             use_imm_o,
    output logic [31:0]      imm_o,
    output logic             mem_load_o,
    output logic             mem_store_o,
    output mem_width_t       mem_width_o
);

    instr_buffer_info_t head;
    logic               not_empty;
    logic               pop;

    instr_queue u_instr_queue (
        .clk         (clk),
        .rst_i       (rst_i),
        .push_i      (push_i),
        .pc_i        (pc_i),
        .instr_i     (instr_i),
        .pop_i       (pop),
        .entry_o     (head),
        .not_empty_o (not_empty),
        .full_o      (full_o)
    );

    decode_stage u_decode_stage (
        .clk               (clk),
        .rst_i             (rst_i),
        .entry_i           (head),
        .not_empty_i       (not_empty),
        .stall_i           (stall_i),
        .pop_o             (pop),
        .dec_valid_o       (dec_valid_o),
        .dec_pc_o          (dec_pc_o),
        .illegal_o         (illegal_o),
        .aluop_o           (aluop_o),
        .alusel_o          (alusel_o),
        .reg_read_valid_o  (reg_read_valid_o),
        .reg_read_addr_o   (reg_read_addr_o),
        .reg_write_valid_o (reg_write_valid_o),
        .reg_write_addr_o  (reg_write_addr_o),
        .use_imm_o         (use_imm_o),
        .imm_o             (imm_o),
        .mem_load_o        (mem_load_o),
        .mem_store_o       (mem_store_o),
        .mem_width_o       (mem_width_o)
    );

endmodule

`default_nettype wire

// ==== tests/tb_decode_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_consts.svh"

module tb_decode_top
    import decode_types::*;
;

    // expected decode of one instruction
    typedef struct packed {
        logic        illegal;
        logic [7:0]  aluop;
        logic [2:0]  alusel;
        logic [1:0]  rv;
        logic [9:0]  ra;
        logic        wv;
        logic [4:0]  wa;
        logic        ui;
        logic [31:0] imm;
        logic        ld;
        logic        st;
        logic [1:0]  width;
    } expect_t;

    logic        clk;
    logic        rst_i;
    logic        push_i;
    logic [31:0] pc_i;
    logic [31:0] instr_i;
    logic        stall_i;
    logic        full_o;
    logic        dec_valid_o;
    logic [31:0] dec_pc_o;
    logic        illegal_o;
    logic [7:0]  aluop_o;
    logic [2:0]  alusel_o;
    logic [1:0]  reg_read_valid_o;
    logic [9:0]  reg_read_addr_o;
    logic        reg_write_valid_o;
    gpr_addr_t   reg_write_addr_o;
    logic        use_imm_o;
    logic [31:0] imm_o;
    logic        mem_load_o;
    logic        mem_store_o;
    mem_width_t  mem_width_o;

    logic [31:0] seed = 32'h266a;
    string       cur_test;
    int          checks;
    int          errors;
    int          errors_at_start;
    bit          stream_done;

    decode_top u_decode_top (
        .clk               (clk),
        .rst_i             (rst_i),
        .push_i            (push_i),
        .pc_i              (pc_i),
        .instr_i           (instr_i),
        .full_o            (full_o),
        .stall_i           (stall_i),
        .dec_valid_o       (dec_valid_o),
        .dec_pc_o          (dec_pc_o),
        .illegal_o         (illegal_o),
        .aluop_o           (aluop_o),
        .alusel_o          (alusel_o),
        .reg_read_valid_o  (reg_read_valid_o),
        .reg_read_addr_o   (reg_read_addr_o),
        .reg_write_valid_o (reg_write_valid_o),
        .reg_write_addr_o  (reg_write_addr_o),
        .use_imm_o         (use_imm_o),
        .imm_o             (imm_o),
        .mem_load_o        (mem_load_o),
        .mem_store_o       (mem_store_o),
        .mem_width_o       (mem_width_o)
    );

    always #10 clk = ~clk;

    function logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // kind 0 is ll.w, 1 sc.w, 2 addi.w, 3..5 ld.b/h/w and 6..8 st.b/h/w
    function automatic logic [31:0] encode_instr(input int kind, input logic [4:0] rd,
                                                 input logic [4:0] rj, input logic [13:0] imm);
        logic [9:0] op;
        if (kind == 0) begin
            return {`EXE_LL_W, imm, rj, rd};
        end
        if (kind == 1) begin
            return {`EXE_SC_W, imm, rj, rd};
        end
        case (kind)
            2:       op = `EXE_ADDI_W;
            3:       op = `EXE_LD_B;
            4:       op = `EXE_LD_H;
            5:       op = `EXE_LD_W;
            6:       op = `EXE_ST_B;
            7:       op = `EXE_ST_H;
            default: op = `EXE_ST_W;
        endcase
        return {op, imm[11:0], rj, rd};
    endfunction

    function automatic expect_t expected_decode(input logic [31:0] instr);
        expect_t     e;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [31:0] imm12;
        logic [31:0] imm14;
        e     = '0;
        rd    = instr[4:0];
        rj    = instr[9:5];
        imm12 = 32'($signed(instr[21:10]));
        // word offset with the low two bits zero
        imm14 = {{16{instr[23]}}, instr[23:10], 2'b00};
        if (instr[31:24] == `EXE_LL_W || instr[31:24] == `EXE_SC_W) begin
            e.alusel = `EXE_RES_MOVE;
            e.wv     = 1'b1;
            e.wa     = rd;
            e.imm    = imm14;
            e.width  = MEM_WORD;
            if (instr[31:24] == `EXE_LL_W) begin
                e.aluop = `EXE_LL_OP;
                e.rv    = 2'b01;
                e.ra    = {5'd0, rj};
                e.ld    = 1'b1;
            end else begin
                e.aluop = `EXE_SC_OP;
                e.rv    = 2'b11;
                e.ra    = {rd, rj};
                e.st    = 1'b1;
            end
            return e;
        end
        case (instr[31:22])
            `EXE_ADDI_W: begin
                e.aluop  = `EXE_ADD_OP;
                e.alusel = `EXE_RES_ARITH;
                e.wv     = 1'b1;
                e.wa     = rd;
                e.rv     = 2'b01;
                e.ra     = {5'd0, rj};
                e.ui     = 1'b1;
                e.imm    = imm12;
            end
            `EXE_LD_B, `EXE_LD_H, `EXE_LD_W: begin
                e.aluop  = `EXE_LOAD_OP;
                e.alusel = `EXE_RES_LOAD_STORE;
                e.wv     = 1'b1;
                e.wa     = rd;
                e.rv     = 2'b01;
                e.ra     = {5'd0, rj};
                e.imm    = imm12;
                e.ld     = 1'b1;
                e.width  = (instr[31:22] == `EXE_LD_B) ? MEM_BYTE :
                           (instr[31:22] == `EXE_LD_H) ? MEM_HALF : MEM_WORD;
            end
            `EXE_ST_B, `EXE_ST_H, `EXE_ST_W: begin
                e.aluop  = `EXE_STORE_OP;
                e.alusel = `EXE_RES_LOAD_STORE;
                e.rv     = 2'b11;
                e.ra     = {rd, rj};
                e.imm    = imm12;
                e.st     = 1'b1;
                e.width  = (instr[31:22] == `EXE_ST_B) ? MEM_BYTE :
                           (instr[31:22] == `EXE_ST_H) ? MEM_HALF : MEM_WORD;
            end
            default: e.illegal = 1'b1;
        endcase
        return e;
    endfunction

    task automatic check(input string field, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s %s: expected %h, actual %h", cur_test, field, exp, act);
        end
    endtask

    task automatic start_test(input string name);
        cur_test        = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        $display("%s done, %0d errors", cur_test, errors - errors_at_start);
    endtask

    // ends on the edge that captures the push
    task automatic drive_push(input logic [31:0] pc, input logic [31:0] instr);
        @(posedge clk);
        push_i  <= 1'b1;
        pc_i    <= pc;
        instr_i <= instr;
        @(posedge clk);
        push_i  <= 1'b0;
    endtask

    task automatic wait_valid(input int limit, output bit ok);
        int n;
        @(negedge clk);
        n = 1;
        while (!dec_valid_o && n < limit) begin
            @(negedge clk);
            n++;
        end
        ok = dec_valid_o;
        if (!ok) begin
            errors++;
            $display("%s: no decoded instruction came out within %0d cycles", cur_test, limit);
        end
    endtask

    task automatic check_fields(input logic [31:0] instr, input logic [31:0] pc);
        expect_t e;
        e = expected_decode(instr);
        check("pc", pc, dec_pc_o);
        check("illegal", e.illegal, illegal_o);
        check("aluop", e.aluop, aluop_o);
        check("alusel", e.alusel, alusel_o);
        check("read valid", e.rv, reg_read_valid_o);
        check("read addr", e.ra, reg_read_addr_o);
        check("write valid", e.wv, reg_write_valid_o);
        check("write addr", e.wa, reg_write_addr_o);
        check("use imm", e.ui, use_imm_o);
        check("imm", e.imm, imm_o);
        check("load", e.ld, mem_load_o);
        check("store", e.st, mem_store_o);
        check("width", e.width, mem_width_o);
    endtask

    task automatic decode_one(input logic [31:0] instr, input logic [31:0] pc);
        bit ok;
        drive_push(pc, instr);
        wait_valid(20, ok);
        if (ok) begin
            check_fields(instr, pc);
        end
    endtask

    task automatic reset_and_atomics();
        logic [31:0] r;
        logic [31:0] instr;
        start_test("reset_and_atomics");
        @(negedge clk);
        check("valid after reset", 0, dec_valid_o);
        check("full after reset", 0, full_o);
        check("illegal after reset", 0, illegal_o);
        check("load after reset", 0, mem_load_o);
        check("store after reset", 0, mem_store_o);
        check("write after reset", 0, reg_write_valid_o);
        for (int k = 0; k < 2; k++) begin
            r     = next_rand();
            instr = encode_instr(k, r[4:0], r[9:5], {1'b1, r[22:10]});
            drive_push(32'h1c00_0000 + 4 * k, instr);
            // valid exactly one edge after the push edge, then a single pulse
            @(negedge clk);
            check("valid early", 0, dec_valid_o);
            @(negedge clk);
            check("valid", 1, dec_valid_o);
            check_fields(instr, 32'h1c00_0000 + 4 * k);
            @(negedge clk);
            check("valid pulse", 0, dec_valid_o);
        end
        finish_test();
    endtask

    task automatic imm12_formats();
        logic [31:0] r;
        start_test("imm12_formats");
        for (int kind = 2; kind < 9; kind++) begin
            for (int s = 0; s < 2; s++) begin
                r = next_rand();
                decode_one(encode_instr(kind, r[4:0], r[9:5], {2'b00, s[0], r[20:10]}),
                           32'h1c00_0100 + 8 * kind + 4 * s);
            end
        end
        finish_test();
    endtask

    task automatic illegal_opcode();
        logic [31:0] r;
        start_test("illegal_opcode");
        r = next_rand();
        decode_one({8'hff, r[23:0]}, 32'h1c00_0200);
        r = next_rand();
        decode_one(encode_instr(2, r[4:0], r[9:5], r[23:10]), 32'h1c00_0204);
        finish_test();
    endtask

    task automatic queue_backpressure();
        logic [31:0] r;
        bit          ok;
        start_test("queue_backpressure");
        @(posedge clk);
        stall_i <= 1'b1;
        for (int i = 0; i < `IQ_DEPTH + 2; i++) begin
            r = next_rand();
            @(posedge clk);
            push_i  <= 1'b1;
            pc_i    <= 32'h8000_0000 + 4 * i;
            instr_i <= encode_instr(5, r[4:0], r[9:5], r[23:10]);
        end
        @(posedge clk);
        push_i <= 1'b0;
        @(negedge clk);
        check("full", 1, full_o);
        check("valid while stalled", 0, dec_valid_o);
        @(posedge clk);
        stall_i <= 1'b0;
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            wait_valid(10, ok);
            if (ok) begin
                check("pc order", 32'h8000_0000 + 4 * i, dec_pc_o);
            end
        end
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            if (dec_valid_o) begin
                errors++;
                $display("%s: a push made while the queue was full came out", cur_test);
            end
        end
        check("full after drain", 0, full_o);
        finish_test();
    endtask

    task automatic random_stream();
        logic [31:0] ins [20];
        logic [31:0] pcs [20];
        logic [31:0] r;
        int          tries;
        bit          ok;
        start_test("random_stream");
        for (int i = 0; i < 20; i++) begin
            r      = next_rand();
            ins[i] = encode_instr(r[31:28] % 9, r[4:0], r[9:5], r[23:10]);
            pcs[i] = 32'h1c00_1000 + 4 * i;
        end
        stream_done = 1'b0;
        fork
            begin
                for (int i = 0; i < 20; i++) begin
                    // push_i is low here, so full_o cannot rise before the next push
                    @(negedge clk);
                    tries = 0;
                    while (full_o && tries < 100) begin
                        @(negedge clk);
                        tries++;
                    end
                    if (full_o) begin
                        errors++;
                        $display("%s: the queue stayed full too long", cur_test);
                    end
                    drive_push(pcs[i], ins[i]);
                end
            end
            begin
                for (int i = 0; i < 20; i++) begin
                    wait_valid(100, ok);
                    if (ok) begin
                        check_fields(ins[i], pcs[i]);
                    end
                end
                stream_done = 1'b1;
            end
            begin
                while (!stream_done) begin
                    @(posedge clk);
                    r = next_rand();
                    stall_i <= r[17];
                end
                stall_i <= 1'b0;
            end
        join
        finish_test();
    endtask

    initial begin
        clk     = 1'b0;
        rst_i   = 1'b1;
        push_i  = 1'b0;
        pc_i    = '0;
        instr_i = '0;
        stall_i = 1'b0;
        checks  = 0;
        errors  = 0;
        repeat (16) @(posedge clk);
        rst_i <= 1'b0;
        reset_and_atomics();
        imm12_formats();
        illegal_opcode();
        queue_backpressure();
        random_stream();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
verilog/core_types.sv
verilog/decode_types.sv
verilog/instr_queue.sv
verilog/decoder_2RI14.sv
verilog/decoder_2RI12.sv
verilog/decode_stage.sv
verilog/decode_top.sv
tests/tb_decode_top.sv

// ==== Bender.yml ====
package:
  name: decode_front

sources:
  - include_dirs:
      - include
    files:
      - verilog/core_types.sv
      - verilog/decode_types.sv
      - verilog/instr_queue.sv
      - verilog/decoder_2RI14.sv
      - verilog/decoder_2RI12.sv
      - verilog/decode_stage.sv
      - verilog/decode_top.sv
      - target: test
        files:
          - tests/tb_decode_top.sv
